// File: hdl/epu_pkg.sv
`default_nettype none

package epu_pkg;

    // AXI field widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;
    localparam int RESP_W = 2;

    // Compute widths
    localparam int ELEM_W = 16;
    localparam int ACC_W  = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [RESP_W-1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // Activations and weights come from the low half of a bus word
    typedef logic signed [ELEM_W-1:0] pixel_t;
    typedef logic signed [ELEM_W-1:0] weight_t;

    // Wraps on overflow
    typedef logic signed [ACC_W-1:0] acc_t;

    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_INPUT,
        REGION_WEIGHT,
        REGION_BIAS,
        REGION_RESULT,
        REGION_CTRL
    } epu_region_e;

    // Regions are 64 KiB, so only the upper address bits select one
    localparam int REGION_BITS = 16;

    localparam addr_t INPUT_BASE  = 32'h5000_0000;
    localparam addr_t RESULT_BASE = 32'h6000_0000;
    localparam addr_t BIAS_BASE   = 32'h7000_0000;
    localparam addr_t WEIGHT_BASE = 32'h7400_0000;
    localparam addr_t CTRL_BASE   = 32'h8000_0000;

endpackage

`default_nettype wire

// File: hdl/epu_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module epu_buffer #(
    parameter type payload_t = logic [15:0],
    parameter int  BUF_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic                         we_i,
    input  logic [$clog2(BUF_DEPTH)-1:0] waddr_i,
    input  payload_t                     wdata_i,
    input  logic [$clog2(BUF_DEPTH)-1:0] raddr_i,
    output payload_t                     rdata_o
);

    // Storage array
    payload_t mem [BUF_DEPTH];

    // Write port, one entry per strobe
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // Registered read port
    // Data follows the address by one cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_o <= '0;
        end else begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

`default_nettype wire

// File: hdl/epu_mac.sv
`timescale 1ns/10ps
`default_nettype none

module epu_mac
    import epu_pkg::*;
#(
    parameter int VEC_LEN   = 16,
    parameter int BUF_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic                         start_i,
    input  acc_t                         bias_i,
    input  pixel_t                       in_data_i,
    input  weight_t                      wt_data_i,
    output logic [$clog2(BUF_DEPTH)-1:0] rd_addr_o,
    output acc_t                         result_o,
    output logic                         busy_o,
    output logic                         done_o
);

    localparam int BUF_AW = $clog2(BUF_DEPTH);
    localparam logic [BUF_AW-1:0] LAST_IDX = BUF_AW'(VEC_LEN - 1);

    logic [BUF_AW-1:0] elem_cnt_q;
    logic              issue_q;
    logic              valid_q;
    logic              last_q;
    logic              launch;
    acc_t              acc_q;
    acc_t              product;

    // Start only counts when idle
    assign launch    = start_i && !busy_o;
    assign rd_addr_o = elem_cnt_q;

    // Both operands sign extended first, product fits in 32 bits
    assign product = acc_t'(in_data_i) * acc_t'(wt_data_i);

    // Element counter
    // Walks both buffers from 0 to VEC_LEN-1, one address per cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            elem_cnt_q <= '0;
            issue_q    <= 1'b0;
        end else if (launch) begin
            elem_cnt_q <= '0;
            issue_q    <= 1'b1;
        end else if (issue_q) begin
            if (elem_cnt_q == LAST_IDX) begin
                issue_q <= 1'b0;
            end else begin
                elem_cnt_q <= elem_cnt_q + 1'b1;
            end
        end
    end

    // Buffer read latency
    // Valid and last line up with the returned data
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= issue_q;
            last_q  <= issue_q && (elem_cnt_q == LAST_IDX);
        end
    end

    // Accumulator, seeded with the bias on launch
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_q    <= '0;
            result_o <= '0;
            busy_o   <= 1'b0;
            done_o   <= 1'b0;
        end else if (launch) begin
            acc_q  <= bias_i;
            busy_o <= 1'b1;
            done_o <= 1'b0;
        end else if (valid_q) begin
            acc_q <= acc_q + product;
            // Final product goes straight into the result
            if (last_q) begin
                result_o <= acc_q + product;
                busy_o   <= 1'b0;
                done_o   <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/epu_axi_slave.sv
`timescale 1ns/10ps
`default_nettype none

module epu_axi_slave
    import epu_pkg::*;
#(
    parameter int BUF_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         arst_n_i,
    // Write address
    input  logic                         awvalid_i,
    output logic                         awready_o,
    input  addr_t                        awaddr_i,
    input  id_t                          awid_i,
    input  len_t                         awlen_i,
    // Write data
    input  logic                         wvalid_i,
    output logic                         wready_o,
    input  data_t                        wdata_i,
    input  logic                         wlast_i,
    // Write response
    output logic                         bvalid_o,
    input  logic                         bready_i,
    output id_t                          bid_o,
    output resp_t                        bresp_o,
    // Read address
    input  logic                         arvalid_i,
    output logic                         arready_o,
    input  addr_t                        araddr_i,
    input  id_t                          arid_i,
    input  len_t                         arlen_i,
    // Read data
    output logic                         rvalid_o,
    input  logic                         rready_i,
    output data_t                        rdata_o,
    output id_t                          rid_o,
    output resp_t                        rresp_o,
    output logic                         rlast_o,
    // Buffer write ports
    output logic                         in_we_o,
    output logic [$clog2(BUF_DEPTH)-1:0] in_waddr_o,
    output pixel_t                       in_wdata_o,
    output logic                         wt_we_o,
    output logic [$clog2(BUF_DEPTH)-1:0] wt_waddr_o,
    output weight_t                      wt_wdata_o,
    // Engine side
    output acc_t                         bias_o,
    output logic                         start_o,
    input  acc_t                         result_i,
    input  logic                         busy_i,
    input  logic                         done_i
);

    localparam int BUF_AW = $clog2(BUF_DEPTH);

    typedef enum logic [1:0] {ST_IDLE, ST_WDATA, ST_RESP, ST_RDATA} state_e;

    state_e            state_q;
    state_e            state_d;
    addr_t             addr_q;
    id_t               id_q;
    len_t              len_q;
    len_t              beat_q;
    epu_region_e       region;
    resp_t             resp;
    logic              aw_hs;
    logic              w_hs;
    logic              b_hs;
    logic              ar_hs;
    logic              r_hs;
    logic [BUF_AW-1:0] buf_addr;
    acc_t              bias_q;
    logic              start_q;

    // Channel handshakes
    assign aw_hs = awvalid_i && awready_o;
    assign w_hs  = wvalid_i && wready_o;
    assign b_hs  = bvalid_o && bready_i;
    assign ar_hs = arvalid_i && arready_o;
    assign r_hs  = rvalid_o && rready_i;

    // Ready and valid straight from the state, write wins in IDLE
    // Read address taken only for a pending request
    assign awready_o = (state_q == ST_IDLE);
    assign arready_o = (state_q == ST_IDLE) && arvalid_i && !awvalid_i;
    assign wready_o  = (state_q == ST_WDATA);
    assign bvalid_o  = (state_q == ST_RESP);
    assign rvalid_o  = (state_q == ST_RDATA);
    assign rlast_o   = (state_q == ST_RDATA) && (beat_q == len_q);

    // Transaction FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (aw_hs) begin
                    state_d = ST_WDATA;
                end else if (ar_hs) begin
                    state_d = ST_RDATA;
                end
            end
            ST_WDATA: if (w_hs && wlast_i) state_d = ST_RESP;
            ST_RESP:  if (b_hs) state_d = ST_IDLE;
            ST_RDATA: if (r_hs && rlast_o) state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Address, ID and length latches, plus beat counter
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            addr_q <= '0;
            id_q   <= '0;
            len_q  <= '0;
            beat_q <= '0;
        end else if (aw_hs) begin
            addr_q <= awaddr_i;
            id_q   <= awid_i;
            len_q  <= awlen_i;
            beat_q <= '0;
        end else if (ar_hs) begin
            addr_q <= araddr_i;
            id_q   <= arid_i;
            len_q  <= arlen_i;
            beat_q <= '0;
        end else if (w_hs || r_hs) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    // Region decode on upper bits of the latched address
    always_comb begin
        case (addr_q[ADDR_W-1:REGION_BITS])
            INPUT_BASE[ADDR_W-1:REGION_BITS]:  region = REGION_INPUT;
            WEIGHT_BASE[ADDR_W-1:REGION_BITS]: region = REGION_WEIGHT;
            BIAS_BASE[ADDR_W-1:REGION_BITS]:   region = REGION_BIAS;
            RESULT_BASE[ADDR_W-1:REGION_BITS]: region = REGION_RESULT;
            CTRL_BASE[ADDR_W-1:REGION_BITS]:   region = REGION_CTRL;
            default:                           region = REGION_NONE;
        endcase
    end

    // Unmapped address gets SLVERR on both channels
    assign resp    = (region == REGION_NONE) ? RESP_SLVERR : RESP_OKAY;
    assign bresp_o = resp;
    assign rresp_o = resp;
    assign bid_o   = id_q;
    assign rid_o   = id_q;

    // Word offset within the region, advanced per beat
    assign buf_addr = addr_q[BUF_AW+1:2] + BUF_AW'(beat_q);

    assign in_we_o    = w_hs && (region == REGION_INPUT);
    assign in_waddr_o = buf_addr;
    assign in_wdata_o = pixel_t'(wdata_i[ELEM_W-1:0]);
    assign wt_we_o    = w_hs && (region == REGION_WEIGHT);
    assign wt_waddr_o = buf_addr;
    assign wt_wdata_o = weight_t'(wdata_i[ELEM_W-1:0]);

    // Bias register and start pulse
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bias_q  <= '0;
            start_q <= 1'b0;
        end else begin
            start_q <= w_hs && (region == REGION_CTRL) && wdata_i[0];
            if (w_hs && (region == REGION_BIAS)) begin
                bias_q <= acc_t'(wdata_i);
            end
        end
    end

    assign bias_o  = bias_q;
    assign start_o = start_q;

    // Read mux, buffers read as zero
    always_comb begin
        case (region)
            REGION_BIAS:   rdata_o = data_t'(bias_q);
            REGION_RESULT: rdata_o = data_t'(result_i);
            REGION_CTRL:   rdata_o = {{(DATA_W-2){1'b0}}, done_i, busy_i};
            default:       rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/epu_top.sv
`timescale 1ns/10ps
`default_nettype none

module epu_top
    import epu_pkg::*;
#(
    parameter int VEC_LEN   = 16,
    parameter int BUF_DEPTH = 64
) (
    input  logic  clk,
    input  logic  arst_n_i,
    // Write address
    input  logic  awvalid_i,
    output logic  awready_o,
    input  addr_t awaddr_i,
    input  id_t   awid_i,
    input  len_t  awlen_i,
    // Write data
    input  logic  wvalid_i,
    output logic  wready_o,
    input  data_t wdata_i,
    input  logic  wlast_i,
    // Write response
    output logic  bvalid_o,
    input  logic  bready_i,
    output id_t   bid_o,
    output resp_t bresp_o,
    // Read address
    input  logic  arvalid_i,
    output logic  arready_o,
    input  addr_t araddr_i,
    input  id_t   arid_i,
    input  len_t  arlen_i,
    // Read data
    output logic  rvalid_o,
    input  logic  rready_i,
    output data_t rdata_o,
    output id_t   rid_o,
    output resp_t rresp_o,
    output logic  rlast_o
);

    localparam int BUF_AW = $clog2(BUF_DEPTH);

    // Slave to buffers
    logic              in_we;
    logic [BUF_AW-1:0] in_waddr;
    pixel_t            in_wdata;
    logic              wt_we;
    logic [BUF_AW-1:0] wt_waddr;
    weight_t           wt_wdata;

    // Slave and engine
    acc_t              bias;
    logic              start;
    acc_t              result;
    logic              busy;
    logic              done;

    // Engine read side, both buffers share the address
    logic [BUF_AW-1:0] rd_addr;
    pixel_t            in_rdata;
    weight_t           wt_rdata;

    // AXI ports share their names with the top, so they go through .*
    epu_axi_slave #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_slave (
        .*,
        .in_we_o    (in_we   ),
        .in_waddr_o (in_waddr),
        .in_wdata_o (in_wdata),
        .wt_we_o    (wt_we   ),
        .wt_waddr_o (wt_waddr),
        .wt_wdata_o (wt_wdata),
        .bias_o     (bias    ),
        .start_o    (start   ),
        .result_i   (result  ),
        .busy_i     (busy    ),
        .done_i     (done    )
    );

    // Input activations
    epu_buffer #(
        .payload_t (pixel_t  ),
        .BUF_DEPTH (BUF_DEPTH)
    ) u_in_buf (
        .clk      (clk     ),
        .arst_n_i (arst_n_i),
        .we_i     (in_we   ),
        .waddr_i  (in_waddr),
        .wdata_i  (in_wdata),
        .raddr_i  (rd_addr ),
        .rdata_o  (in_rdata)
    );

    // Weights
    epu_buffer #(
        .payload_t (weight_t ),
        .BUF_DEPTH (BUF_DEPTH)
    ) u_wt_buf (
        .clk      (clk     ),
        .arst_n_i (arst_n_i),
        .we_i     (wt_we   ),
        .waddr_i  (wt_waddr),
        .wdata_i  (wt_wdata),
        .raddr_i  (rd_addr ),
        .rdata_o  (wt_rdata)
    );

    epu_mac #(
        .VEC_LEN   (VEC_LEN  ),
        .BUF_DEPTH (BUF_DEPTH)
    ) u_mac (
        .clk       (clk     ),
        .arst_n_i  (arst_n_i),
        .start_i   (start   ),
        .bias_i    (bias    ),
        .in_data_i (in_rdata),
        .wt_data_i (wt_rdata),
        .rd_addr_o (rd_addr ),
        .result_o  (result  ),
        .busy_o    (busy    ),
        .done_o    (done    )
    );

endmodule

`default_nettype wire

// File: testbench/tb_epu_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_epu_top
    import epu_pkg::*;
();

    localparam int VEC_LEN    = 16;
    localparam int WAIT_LIMIT = 50;
    localparam int POLL_LIMIT = 20;
    localparam int N_CASES    = 5;

    typedef enum int {F_AWREADY, F_WREADY, F_BVALID, F_ARREADY, F_RVALID} flag_e;

    logic  clk;
    logic  arst_n_i;
    logic  awvalid_i, wvalid_i, wlast_i, bready_i, arvalid_i, rready_i;
    logic  awready_o, wready_o, bvalid_o, arready_o, rvalid_o, rlast_o;
    addr_t awaddr_i, araddr_i;
    id_t   awid_i, arid_i, bid_o, rid_o;
    len_t  awlen_i, arlen_i;
    data_t wdata_i, rdata_o;
    resp_t bresp_o, rresp_o;

    // Case table: bias, split load into halves, bready hold cycles
    acc_t  case_bias   [N_CASES];
    logic  case_split  [N_CASES];
    int    case_bstall [N_CASES];

    // Beats to send, beats received
    data_t beat_buf [256];
    data_t rd_buf   [256];

    // Current operand vectors, sign extended words
    data_t pix_vec [VEC_LEN];
    data_t wt_vec  [VEC_LEN];

    logic [31:0] lcg_state;

    epu_top epu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper LCG bits make a 16-bit element
    function data_t rand_elem();
        logic [31:0] r;
        r = lcg_next();
        return {{16{r[31]}}, r[31:16]};
    endfunction

    // Reference dot product, wide sum then wrap to 32 bits
    function automatic acc_t model_dot(input acc_t bias);
        longint sum;
        sum = longint'(bias);
        for (int i = 0; i < VEC_LEN; i++) begin
            sum += longint'($signed(pix_vec[i][15:0])) * longint'($signed(wt_vec[i][15:0]));
        end
        return acc_t'(sum[31:0]);
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("error at %0t: %s: got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_resp(input resp_t got, input resp_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("error at %0t: %s: got %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_result(input acc_t got, input acc_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("error at %0t: %s: got %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_id(input id_t got, input id_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("error at %0t: %s: got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("error at %0t: %s: got %b, expected %b", $time, what, got, exp));
        end
    endtask

    function automatic logic flag_value(input flag_e which);
        case (which)
            F_AWREADY: return awready_o;
            F_WREADY:  return wready_o;
            F_BVALID:  return bvalid_o;
            F_ARREADY: return arready_o;
            default:   return rvalid_o;
        endcase
    endfunction

    // Sampled 1 ns after the falling edge, where outputs are settled
    task automatic wait_for(input flag_e which, input string what);
        int cycles;
        cycles = 0;
        #1;
        while (flag_value(which) !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                stop_run($sformatf("timeout waiting for %s", what));
            end
            cycles++;
            @(negedge clk);
            #1;
        end
    endtask

    task automatic axi_write_burst(input addr_t addr, input id_t id, input int beats,
                                   input int b_hold, input resp_t exp_resp);
        resp_t held_resp;
        id_t   held_id;
        awvalid_i = 1'b1;
        awaddr_i  = addr;
        awid_i    = id;
        awlen_i   = len_t'(beats - 1);
        wait_for(F_AWREADY, "awready");
        @(posedge clk);
        @(negedge clk);
        awvalid_i = 1'b0;
        for (int i = 0; i < beats; i++) begin
            wvalid_i = 1'b1;
            wdata_i  = beat_buf[i];
            wlast_i  = (i == beats - 1);
            wait_for(F_WREADY, "wready");
            @(posedge clk);
            @(negedge clk);
        end
        wvalid_i = 1'b0;
        wlast_i  = 1'b0;
        // No hold, so bready goes up ahead of bvalid
        bready_i = (b_hold == 0);
        wait_for(F_BVALID, "bvalid");
        if (b_hold > 0) begin
            held_resp = bresp_o;
            held_id   = bid_o;
            repeat (b_hold) begin
                @(negedge clk);
                #1;
                check_bit(bvalid_o, 1'b1, "bvalid while bready low");
                check_resp(bresp_o, held_resp, "bresp while bready low");
                check_id(bid_o, held_id, "bid while bready low");
            end
            @(negedge clk);
            bready_i = 1'b1;
            #1;
        end
        check_id(bid_o, id, "bid");
        check_resp(bresp_o, exp_resp, "bresp");
        @(posedge clk);
        @(negedge clk);
        bready_i = 1'b0;
    endtask

    // Beat stall_beat is held with rready low for stall cycles
    task automatic axi_read_burst(input addr_t addr, input id_t id, input int beats,
                                  input int stall_beat, input int stall, input resp_t exp_resp);
        data_t held;
        arvalid_i = 1'b1;
        araddr_i  = addr;
        arid_i    = id;
        arlen_i   = len_t'(beats - 1);
        wait_for(F_ARREADY, "arready");
        @(posedge clk);
        @(negedge clk);
        arvalid_i = 1'b0;
        for (int i = 0; i < beats; i++) begin
            rready_i = !(i == stall_beat && stall > 0);
            wait_for(F_RVALID, "rvalid");
            if (!rready_i) begin
                held = rdata_o;
                repeat (stall) begin
                    @(negedge clk);
                    #1;
                    check_bit(rvalid_o, 1'b1, "rvalid while rready low");
                    check_data(rdata_o, held, "rdata while rready low");
                end
                @(negedge clk);
                rready_i = 1'b1;
                #1;
            end
            rd_buf[i] = rdata_o;
            check_id(rid_o, id, "rid");
            check_resp(rresp_o, exp_resp, "rresp");
            check_bit(rlast_o, i == beats - 1, "rlast");
            @(posedge clk);
            @(negedge clk);
        end
        rready_i = 1'b0;
    endtask

    // Whole vector in one burst, or two half bursts
    task automatic load_vector(input addr_t base, input logic is_wt, input logic split,
                               input int b_hold, input id_t id);
        int half;
        half = VEC_LEN / 2;
        for (int i = 0; i < VEC_LEN; i++) begin
            beat_buf[i] = is_wt ? wt_vec[i] : pix_vec[i];
        end
        if (!split) begin
            axi_write_burst(base, id, VEC_LEN, b_hold, RESP_OKAY);
        end else begin
            axi_write_burst(base, id, half, b_hold, RESP_OKAY);
            for (int i = 0; i < half; i++) begin
                beat_buf[i] = is_wt ? wt_vec[half + i] : pix_vec[half + i];
            end
            axi_write_burst(base + addr_t'(4 * half), id, half, b_hold, RESP_OKAY);
        end
    endtask

    initial begin : main
        acc_t expected;
        int   polls;
        lcg_state = 32'd77879;
        arst_n_i  = 1'b0;
        awvalid_i = 1'b0;
        awaddr_i  = '0;
        awid_i    = '0;
        awlen_i   = '0;
        wvalid_i  = 1'b0;
        wdata_i   = '0;
        wlast_i   = 1'b0;
        bready_i  = 1'b0;
        arvalid_i = 1'b0;
        araddr_i  = '0;
        arid_i    = '0;
        arlen_i   = '0;
        rready_i  = 1'b0;
        expected  = '0;
        case_bias   = '{32'sd0, 32'sd4660, -32'sd1000, 32'sh7FFF_FF00, 32'sh8000_0010};
        case_split  = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1};
        case_bstall = '{0, 2, 0, 5, 1};

        repeat (10) @(negedge clk);
        arst_n_i = 1'b1;
        #1;
        check_bit(awready_o, 1'b1, "awready after reset");
        check_bit(arready_o, 1'b0, "arready after reset");
        check_bit(wready_o, 1'b0, "wready after reset");
        check_bit(bvalid_o, 1'b0, "bvalid after reset");
        check_bit(rvalid_o, 1'b0, "rvalid after reset");
        @(negedge clk);

        // Idle engine, cleared result
        axi_read_burst(CTRL_BASE, 4'h1, 1, 0, 0, RESP_OKAY);
        check_data(rd_buf[0], '0, "ctrl after reset");
        axi_read_burst(RESULT_BASE, 4'h2, 1, 0, 0, RESP_OKAY);
        check_result(acc_t'(rd_buf[0]), '0, "result after reset");

        // Bias round trip, B held off for 3 cycles
        beat_buf[0] = 32'hCAFE_1234;
        axi_write_burst(BIAS_BASE, 4'h5, 1, 3, RESP_OKAY);
        axi_read_burst(BIAS_BASE, 4'h6, 1, 0, 0, RESP_OKAY);
        check_data(rd_buf[0], 32'hCAFE_1234, "bias readback");
        // Same register on every beat, middle beat stalled
        axi_read_burst(BIAS_BASE, 4'h7, 3, 1, 4, RESP_OKAY);
        for (int i = 0; i < 3; i++) begin
            check_data(rd_buf[i], 32'hCAFE_1234, $sformatf("bias burst beat %0d", i));
        end

        for (int c = 0; c < N_CASES; c++) begin
            for (int i = 0; i < VEC_LEN; i++) begin
                pix_vec[i] = rand_elem();
                wt_vec[i]  = rand_elem();
            end
            beat_buf[0] = data_t'(case_bias[c]);
            axi_write_burst(BIAS_BASE, id_t'(c), 1, case_bstall[c], RESP_OKAY);
            load_vector(INPUT_BASE, 1'b0, case_split[c], case_bstall[c], id_t'(c + 1));
            load_vector(WEIGHT_BASE, 1'b1, case_split[c], case_bstall[c], id_t'(c + 2));
            expected = model_dot(case_bias[c]);

            beat_buf[0] = 32'h1;
            axi_write_burst(CTRL_BASE, id_t'(c + 3), 1, 0, RESP_OKAY);
            // Engine is still running here
            axi_read_burst(CTRL_BASE, id_t'(c + 4), 1, 0, 0, RESP_OKAY);
            check_data(rd_buf[0], 32'h1, "ctrl right after start");

            polls = 0;
            while (rd_buf[0][1] !== 1'b1) begin
                if (polls == POLL_LIMIT) begin
                    stop_run("timeout: done never set in the ctrl register");
                end
                polls++;
                axi_read_burst(CTRL_BASE, id_t'(c + 5), 1, 0, 0, RESP_OKAY);
            end
            check_data(rd_buf[0], 32'h2, "ctrl after completion");
            axi_read_burst(RESULT_BASE, id_t'(c + 6), 1, 0, 0, RESP_OKAY);
            check_result(acc_t'(rd_buf[0]), expected, $sformatf("result of case %0d", c));
        end

        // Unmapped address, no side effect on the result
        beat_buf[0] = 32'h1234_5678;
        axi_write_burst(32'h9000_0000, 4'hA, 1, 0, RESP_SLVERR);
        axi_read_burst(32'h9000_0000, 4'hB, 1, 0, 0, RESP_SLVERR);
        check_data(rd_buf[0], '0, "unmapped read data");
        axi_read_burst(RESULT_BASE, 4'hC, 1, 0, 0, RESP_OKAY);
        check_result(acc_t'(rd_buf[0]), expected, "result after unmapped access");

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: epu_top.f
hdl/epu_pkg.sv
hdl/epu_buffer.sv
hdl/epu_mac.sv
hdl/epu_axi_slave.sv
hdl/epu_top.sv
testbench/tb_epu_top.sv

// File: Bender.yml
package:
  name: epu_top

sources:
  - hdl/epu_pkg.sv
  - hdl/epu_buffer.sv
  - hdl/epu_mac.sv
  - hdl/epu_axi_slave.sv
  - hdl/epu_top.sv
  - target: test
    files:
      - testbench/tb_epu_top.sv
